// File: common/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

//////////////////////////////////////////////////
// register file sizes
//////////////////////////////////////////////////

// architectural registers seen by software
`define RN_NUM_ARCH 32

// physical registers behind the rename map
`define RN_NUM_PHYS 64

//////////////////////////////////////////////////
// queue depths and port counts
//////////////////////////////////////////////////

// in-flight instructions
`define RN_ROB_DEPTH 16

// completion requesters feeding the cdb
`define RN_CDB_PORTS 4

`endif

// File: common/reg_pkg.sv
`default_nettype none

`include "rename_params.svh"

package reg_pkg;

  // architectural register name
  typedef logic [$clog2(`RN_NUM_ARCH)-1:0] arch_reg_t;

  // physical register tag
  typedef logic [$clog2(`RN_NUM_PHYS)-1:0] phys_reg_t;

  // one speculative map slot
  // ready means the value has been broadcast
  typedef struct packed {
    phys_reg_t tag;
    logic      ready;
  } map_entry_t;

  // free list occupancy, 0 up to phys minus arch
  typedef logic [$clog2(`RN_NUM_PHYS - `RN_NUM_ARCH):0] fl_count_t;

endpackage

`default_nettype wire

// File: common/rob_pkg.sv
`default_nettype none

`include "rename_params.svh"

package rob_pkg;
  import reg_pkg::*;

  // slot index, wraps at depth
  typedef logic [$clog2(`RN_ROB_DEPTH)-1:0] rob_idx_t;

  // occupancy, one extra bit for full
  typedef logic [$clog2(`RN_ROB_DEPTH):0] rob_count_t;

  // one in-flight instruction
  typedef struct packed {
    arch_reg_t dest;
    phys_reg_t tag_new;
    phys_reg_t tag_old;
    logic      done;
  } rob_entry_t;

endpackage

`default_nettype wire

// File: rename/map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// speculative arch to phys map with ready bits
module map_table
  import reg_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  // dispatch side
  input  logic       accept,
  input  arch_reg_t  dest,
  input  arch_reg_t  src_a,
  input  arch_reg_t  src_b,
  input  phys_reg_t  tag_new,
  // broadcast side
  input  logic       cdb_valid,
  input  phys_reg_t  cdb_tag,
  // lookups
  output map_entry_t map_a,
  output map_entry_t map_b,
  output phys_reg_t  tag_old
);

  // one slot per arch register
  map_entry_t map_q [`RN_NUM_ARCH];

  //////////////////////////////////////////////////
  // lookups
  //////////////////////////////////////////////////

  // read stored state only
  // no bypass of this cycle's write or broadcast
  assign map_a = map_q[src_a];
  assign map_b = map_q[src_b];

  // previous mapping of dest, goes to the rob
  assign tag_old = map_q[dest].tag;

  //////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, everything ready
      for (int i = 0; i < `RN_NUM_ARCH; i++) begin
        map_q[i].tag   <= phys_reg_t'(i);
        map_q[i].ready <= 1'b1;
      end
    end else begin
      // wakeup by tag match
      // several arch regs can't share a live tag, but scan all anyway
      if (cdb_valid) begin
        for (int i = 0; i < `RN_NUM_ARCH; i++) begin
          if (map_q[i].tag == cdb_tag) begin
            map_q[i].ready <= 1'b1;
          end
        end
      end
      // rename dest
      // placed last so it overrides a wakeup on the same slot
      if (accept) begin
        map_q[dest].tag   <= tag_new;
        map_q[dest].ready <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rename/free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// circular queue of free physical tags
module free_list
  import reg_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      pop,
  input  logic      push,
  input  phys_reg_t push_tag,
  output phys_reg_t head_tag,
  output logic      empty,
  output fl_count_t free_count
);

  // only tags beyond the arch set can ever be free at once
  localparam int FL_DEPTH = `RN_NUM_PHYS - `RN_NUM_ARCH;
  localparam int PTR_W    = $clog2(FL_DEPTH);

  phys_reg_t        slots_q [FL_DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  fl_count_t        count_q;
  logic             pop_ok;

  // never pop past empty
  assign pop_ok = pop & ~empty;

  assign empty      = (count_q == '0);
  assign head_tag   = slots_q[head_q];
  assign free_count = count_q;

  //////////////////////////////////////////////////
  // queue state
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // full at reset with tags above the arch range, in order
      for (int i = 0; i < FL_DEPTH; i++) begin
        slots_q[i] <= phys_reg_t'(`RN_NUM_ARCH + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= fl_count_t'(FL_DEPTH);
    end else begin
      // freed tag lands at tail, visible next cycle at earliest
      if (push) begin
        slots_q[tail_q] <= push_tag;
        tail_q          <= tail_q + 1'b1;
      end
      if (pop_ok) begin
        head_q <= head_q + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rename/arch_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// committed arch to phys map
module arch_map
  import reg_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  // retire write
  input  logic      retire_valid,
  input  arch_reg_t retire_dest,
  input  phys_reg_t retire_tag,
  // lookup
  input  arch_reg_t query_arch,
  output phys_reg_t query_tag
);

  phys_reg_t arch_q [`RN_NUM_ARCH];

  // combinational read of committed state
  assign query_tag = arch_q[query_arch];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity, same as speculative map at reset
      for (int i = 0; i < `RN_NUM_ARCH; i++) begin
        arch_q[i] <= phys_reg_t'(i);
      end
    end else if (retire_valid) begin
      arch_q[retire_dest] <= retire_tag;
    end
  end

endmodule

`default_nettype wire

// File: rob/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// in-order queue of dispatched instructions
module reorder_buffer
  import reg_pkg::*;
  import rob_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  // dispatch
  input  logic       dispatch_valid,
  input  logic       fl_empty,
  input  arch_reg_t  dest,
  input  phys_reg_t  tag_new,
  input  phys_reg_t  tag_old,
  // completion broadcast
  input  logic       cdb_valid,
  input  phys_reg_t  cdb_tag,
  // handshake
  output logic       dispatch_ready,
  output logic       accept,
  // retire
  output logic       retire_valid,
  output arch_reg_t  retire_dest,
  output phys_reg_t  retire_tag,
  output phys_reg_t  retire_tag_old,
  output rob_count_t rob_count
);

  rob_entry_t               entries_q [`RN_ROB_DEPTH];
  logic [`RN_ROB_DEPTH-1:0] valid_q;
  rob_idx_t                 head_q;
  rob_idx_t                 tail_q;
  rob_count_t               count_q;
  logic                     full;
  rob_entry_t               head_entry;

  //////////////////////////////////////////////////
  // dispatch handshake
  //////////////////////////////////////////////////

  assign full = (count_q == rob_count_t'(`RN_ROB_DEPTH));

  // need a slot here and a tag from the free list
  assign dispatch_ready = ~full & ~fl_empty;
  assign accept         = dispatch_valid & dispatch_ready;

  //////////////////////////////////////////////////
  // retire port
  //////////////////////////////////////////////////

  assign head_entry     = entries_q[head_q];
  assign retire_valid   = valid_q[head_q] & head_entry.done;
  assign retire_dest    = head_entry.dest;
  assign retire_tag     = head_entry.tag_new;
  assign retire_tag_old = head_entry.tag_old;
  assign rob_count      = count_q;

  // pointers, count and valid bits
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (accept) begin
        valid_q[tail_q] <= 1'b1;
        tail_q          <= tail_q + 1'b1;
      end
      // head and tail only meet when empty or full, so no clash here
      if (retire_valid) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      case ({accept, retire_valid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    // mark done on tag match, valid slots only
    if (cdb_valid) begin
      for (int i = 0; i < `RN_ROB_DEPTH; i++) begin
        if (valid_q[i] && entries_q[i].tag_new == cdb_tag) begin
          entries_q[i].done <= 1'b1;
        end
      end
    end
    // new entry starts not done
    if (accept) begin
      entries_q[tail_q] <= '{dest: dest, tag_new: tag_new, tag_old: tag_old, done: 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: rtl/cdb_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// fixed priority pick of one completion, registered onto the bus
module cdb_select
  import reg_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`RN_CDB_PORTS-1:0] done_valid,
  input  phys_reg_t                done_tag [`RN_CDB_PORTS],
  output logic [`RN_CDB_PORTS-1:0] done_grant,
  output logic                     cdb_valid,
  output phys_reg_t                cdb_tag
);

  phys_reg_t grant_tag;

  // lowest set bit wins
  assign done_grant = done_valid & (~done_valid + 1'b1);

  // grant is one-hot, so a plain scan picks the tag
  always_comb begin
    grant_tag = '0;
    for (int i = 0; i < `RN_CDB_PORTS; i++) begin
      if (done_grant[i]) begin
        grant_tag = done_tag[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // bus register, one cycle after grant
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= |done_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (|done_valid) begin
      cdb_tag <= grant_tag;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// rename and in-order retire core
module rename_core
  import reg_pkg::*;
  import rob_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  // dispatch in
  input  logic                     dispatch_valid,
  input  arch_reg_t                dispatch_dest,
  input  arch_reg_t                dispatch_src_a,
  input  arch_reg_t                dispatch_src_b,
  // dispatch out
  output logic                     dispatch_ready,
  output phys_reg_t                tag_a,
  output logic                     ready_a,
  output phys_reg_t                tag_b,
  output logic                     ready_b,
  output phys_reg_t                tag_new,
  output phys_reg_t                tag_old,
  // completion
  input  logic [`RN_CDB_PORTS-1:0] done_valid,
  input  phys_reg_t                done_tag [`RN_CDB_PORTS],
  output logic [`RN_CDB_PORTS-1:0] done_grant,
  output logic                     cdb_valid,
  output phys_reg_t                cdb_tag,
  // retire
  output logic                     retire_valid,
  output arch_reg_t                retire_dest,
  output phys_reg_t                retire_tag,
  output phys_reg_t                retire_tag_old,
  // status
  input  arch_reg_t                query_arch,
  output phys_reg_t                query_tag,
  output fl_count_t                free_count,
  output rob_count_t               rob_count
);

  logic       accept;
  logic       fl_empty;
  map_entry_t map_a;
  map_entry_t map_b;

  assign tag_a   = map_a.tag;
  assign ready_a = map_a.ready;
  assign tag_b   = map_b.tag;
  assign ready_b = map_b.ready;

  //////////////////////////////////////////////////
  // rename
  //////////////////////////////////////////////////

  map_table u_map (
    .clock     (clock),
    .reset     (reset),
    .accept    (accept),
    .dest      (dispatch_dest),
    .src_a     (dispatch_src_a),
    .src_b     (dispatch_src_b),
    .tag_new   (tag_new),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .map_a     (map_a),
    .map_b     (map_b),
    .tag_old   (tag_old)
  );

  // pop on dispatch, push the old tag on retire
  free_list u_free (
    .clock      (clock),
    .reset      (reset),
    .pop        (accept),
    .push       (retire_valid),
    .push_tag   (retire_tag_old),
    .head_tag   (tag_new),
    .empty      (fl_empty),
    .free_count (free_count)
  );

  arch_map u_arch (
    .clock        (clock),
    .reset        (reset),
    .retire_valid (retire_valid),
    .retire_dest  (retire_dest),
    .retire_tag   (retire_tag),
    .query_arch   (query_arch),
    .query_tag    (query_tag)
  );

  //////////////////////////////////////////////////
  // tracking and completion
  //////////////////////////////////////////////////

  reorder_buffer u_rob (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .fl_empty       (fl_empty),
    .dest           (dispatch_dest),
    .tag_new        (tag_new),
    .tag_old        (tag_old),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .dispatch_ready (dispatch_ready),
    .accept         (accept),
    .retire_valid   (retire_valid),
    .retire_dest    (retire_dest),
    .retire_tag     (retire_tag),
    .retire_tag_old (retire_tag_old),
    .rob_count      (rob_count)
  );

  cdb_select u_cdb (
    .clock      (clock),
    .reset      (reset),
    .done_valid (done_valid),
    .done_tag   (done_tag),
    .done_grant (done_grant),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag)
  );

endmodule

`default_nettype wire

// File: test/tb_reference.svh
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

//////////////////////////////////////////////////
// reference model state
//////////////////////////////////////////////////

// speculative map, tag and ready per arch reg
phys_reg_t  ref_tag   [`RN_NUM_ARCH];
logic       ref_ready [`RN_NUM_ARCH];
// committed map
phys_reg_t  ref_arch  [`RN_NUM_ARCH];
// free tags, next to hand out at index 0
phys_reg_t  ref_free  [$];
// in-flight instructions, oldest first
rob_entry_t ref_rob   [$];
// bus contents due after the next edge
logic       ref_cdb_valid;
phys_reg_t  ref_cdb_tag;

// random generator state
logic [31:0] rng_state = 32'd61332;

function automatic logic [31:0] xorshift();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// identity maps, upper tags free in order, nothing in flight
function automatic void model_reset();
  for (int i = 0; i < `RN_NUM_ARCH; i++) begin
    ref_tag[i]   = phys_reg_t'(i);
    ref_ready[i] = 1'b1;
    ref_arch[i]  = phys_reg_t'(i);
  end
  ref_free.delete();
  for (int i = `RN_NUM_ARCH; i < `RN_NUM_PHYS; i++) begin
    ref_free.push_back(phys_reg_t'(i));
  end
  ref_rob.delete();
  ref_cdb_valid = 1'b0;
  ref_cdb_tag   = '0;
endfunction

//////////////////////////////////////////////////
// expected responses
//////////////////////////////////////////////////

// a free rob slot and a free tag are both needed
function automatic logic expect_ready();
  return (ref_rob.size() < `RN_ROB_DEPTH) && (ref_free.size() > 0);
endfunction

function automatic phys_reg_t expect_tag_new();
  return ref_free[0];
endfunction

function automatic phys_reg_t expect_tag_old(input arch_reg_t dest);
  return ref_tag[dest];
endfunction

// lowest requesting port wins
function automatic logic [`RN_CDB_PORTS-1:0] expect_grant(
  input logic [`RN_CDB_PORTS-1:0] req
);
  logic [`RN_CDB_PORTS-1:0] grant;
  grant = '0;
  for (int i = `RN_CDB_PORTS - 1; i >= 0; i--) begin
    if (req[i]) begin
      grant    = '0;
      grant[i] = 1'b1;
    end
  end
  return grant;
endfunction

// only the oldest entry may leave, once done
function automatic logic expect_retire();
  rob_entry_t head;
  if (ref_rob.size() == 0) begin
    return 1'b0;
  end
  head = ref_rob[0];
  return head.done;
endfunction

// advance the model across one rising edge
function automatic void model_step(
  input logic                     acc,
  input logic                     ret,
  input logic [`RN_CDB_PORTS-1:0] grant
);
  rob_entry_t e;
  // retire pops the head and recycles its old tag
  if (ret) begin
    e = ref_rob.pop_front();
    ref_free.push_back(e.tag_old);
    ref_arch[e.dest] = e.tag_new;
  end
  // broadcast wakes map slots and rob entries by tag
  if (ref_cdb_valid) begin
    for (int i = 0; i < `RN_NUM_ARCH; i++) begin
      if (ref_tag[i] == ref_cdb_tag) begin
        ref_ready[i] = 1'b1;
      end
    end
    for (int j = 0; j < ref_rob.size(); j++) begin
      e = ref_rob[j];
      if (e.tag_new == ref_cdb_tag) begin
        e.done     = 1'b1;
        ref_rob[j] = e;
      end
    end
  end
  // rename after wakeup, so the new mapping starts not ready
  if (acc) begin
    e.dest    = dispatch_dest;
    e.tag_new = ref_free.pop_front();
    e.tag_old = ref_tag[dispatch_dest];
    e.done    = 1'b0;
    ref_rob.push_back(e);
    ref_tag[dispatch_dest]   = e.tag_new;
    ref_ready[dispatch_dest] = 1'b0;
  end
  // granted tag shows on the bus one cycle later
  ref_cdb_valid = |grant;
  for (int i = 0; i < `RN_CDB_PORTS; i++) begin
    if (grant[i]) begin
      ref_cdb_tag = done_tag[i];
    end
  end
endfunction

`endif

// File: test/tb_rename_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module tb_rename_core
  import reg_pkg::*;
  import rob_pkg::*;
();

  // test lengths in cycles, limit is twice their sum
  localparam int RESET_CYCLES  = 16;
  localparam int SWEEP_CYCLES  = `RN_NUM_ARCH;
  localparam int RANDOM_CYCLES = 1200;
  localparam int DRAIN_BUDGET  = 252;
  localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + SWEEP_CYCLES + RANDOM_CYCLES + DRAIN_BUDGET);

  logic                     clock;
  logic                     reset;
  logic                     dispatch_valid;
  arch_reg_t                dispatch_dest;
  arch_reg_t                dispatch_src_a;
  arch_reg_t                dispatch_src_b;
  logic                     dispatch_ready;
  phys_reg_t                tag_a;
  logic                     ready_a;
  phys_reg_t                tag_b;
  logic                     ready_b;
  phys_reg_t                tag_new;
  phys_reg_t                tag_old;
  logic [`RN_CDB_PORTS-1:0] done_valid;
  phys_reg_t                done_tag [`RN_CDB_PORTS];
  logic [`RN_CDB_PORTS-1:0] done_grant;
  logic                     cdb_valid;
  phys_reg_t                cdb_tag;
  logic                     retire_valid;
  arch_reg_t                retire_dest;
  phys_reg_t                retire_tag;
  phys_reg_t                retire_tag_old;
  arch_reg_t                query_arch;
  phys_reg_t                query_tag;
  fl_count_t                free_count;
  rob_count_t               rob_count;

  // stimulus bookkeeping
  phys_reg_t                pend_q [$];
  logic [`RN_CDB_PORTS-1:0] granted = '0;
  logic                     last_accept = 1'b0;
  phys_reg_t                last_accept_tag = '0;
  arch_reg_t                last_retire_dest = '0;
  int                       accept_count = 0;
  int                       cycle_count = 0;

  `include "tb_reference.svh"

  // port names match one to one
  rename_core u_dut (.*);

  always #50 clock = ~clock;

  //////////////////////////////////////////////////
  // checks and timeout
  //////////////////////////////////////////////////

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Regression failed");
      $fatal(1, "run exceeded the cycle limit of %0d", CYCLE_LIMIT);
    end
  end

  // compare against the model before this edge takes effect
  always @(posedge clock) begin
    logic [`RN_CDB_PORTS-1:0] exp_grant;
    logic                     acc;
    logic                     ret;
    rob_entry_t               head;
    if (reset) begin
      model_reset();
      granted     = '0;
      last_accept = 1'b0;
    end else begin
      exp_grant = expect_grant(done_valid);
      acc       = dispatch_valid & expect_ready();
      ret       = expect_retire();
      check(32'(dispatch_ready), 32'(expect_ready()), "dispatch_ready");
      check(32'(tag_a), 32'(ref_tag[dispatch_src_a]), "tag_a");
      check(32'(ready_a), 32'(ref_ready[dispatch_src_a]), "ready_a");
      check(32'(tag_b), 32'(ref_tag[dispatch_src_b]), "tag_b");
      check(32'(ready_b), 32'(ref_ready[dispatch_src_b]), "ready_b");
      check(32'(tag_old), 32'(expect_tag_old(dispatch_dest)), "tag_old");
      if (ref_free.size() > 0) begin
        check(32'(tag_new), 32'(expect_tag_new()), "tag_new");
      end
      // completion bus
      check(32'(done_grant), 32'(exp_grant), "done_grant");
      check(32'(cdb_valid), 32'(ref_cdb_valid), "cdb_valid");
      if (ref_cdb_valid) begin
        check(32'(cdb_tag), 32'(ref_cdb_tag), "cdb_tag");
      end
      // retire port, program order
      check(32'(retire_valid), 32'(ret), "retire_valid");
      if (ret) begin
        head = ref_rob[0];
        check(32'(retire_dest), 32'(head.dest), "retire_dest");
        check(32'(retire_tag), 32'(head.tag_new), "retire_tag");
        check(32'(retire_tag_old), 32'(head.tag_old), "retire_tag_old");
        last_retire_dest = head.dest;
      end
      check(32'(query_tag), 32'(ref_arch[query_arch]), "query_tag");
      check(32'(free_count), 32'(ref_free.size()), "free_count");
      check(32'(rob_count), 32'(ref_rob.size()), "rob_count");
      if (acc) begin
        last_accept_tag = expect_tag_new();
        accept_count++;
      end
      last_accept = acc;
      granted     = exp_grant;
      model_step(acc, ret, exp_grant);
    end
  end

  //////////////////////////////////////////////////
  // stimulus, falling edge only
  //////////////////////////////////////////////////

  // one cycle of random inputs, holding what was not accepted
  task automatic drive_random(input logic disp_on, input logic comp_on);
    int pick;
    if (last_accept) begin
      pend_q.push_back(last_accept_tag);
    end
    // granted ports drop, the rest keep waiting
    done_valid = done_valid & ~granted;
    for (int i = 0; i < `RN_CDB_PORTS; i++) begin
      if (comp_on && !done_valid[i] && pend_q.size() > 0 && xorshift() % 2 == 1) begin
        pick = int'(xorshift() % 32'(pend_q.size()));
        done_tag[i] = pend_q[pick];
        pend_q.delete(pick);
        done_valid[i] = 1'b1;
      end
    end
    if (!(dispatch_valid && !last_accept)) begin
      dispatch_valid = disp_on && (xorshift() % 8 < 5);
      dispatch_dest  = arch_reg_t'(xorshift());
      dispatch_src_a = arch_reg_t'(xorshift());
      dispatch_src_b = arch_reg_t'(xorshift());
    end
    // often look at the register that retired last
    query_arch = (xorshift() % 2 == 1) ? last_retire_dest : arch_reg_t'(xorshift());
  endtask

  // stop dispatching and let everything in flight retire
  task automatic drain_all();
    do begin
      @(negedge clock);
      drive_random(1'b0, 1'b1);
    end while (ref_rob.size() > 0 || dispatch_valid || pend_q.size() > 0 || done_valid != '0);
  endtask

  initial begin
    int hold_count;
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    dispatch_src_a = '0;
    dispatch_src_b = '0;
    done_valid     = '0;
    query_arch     = '0;
    for (int i = 0; i < `RN_CDB_PORTS; i++) begin
      done_tag[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // reset state, one source pair per cycle
    for (int i = 0; i < SWEEP_CYCLES; i++) begin
      dispatch_src_a = arch_reg_t'(i);
      dispatch_src_b = arch_reg_t'(SWEEP_CYCLES - 1 - i);
      query_arch     = arch_reg_t'(i);
      @(negedge clock);
    end

    // mixed dispatch, completion and retire
    repeat (RANDOM_CYCLES) begin
      @(negedge clock);
      drive_random(1'b1, 1'b1);
    end
    drain_all();

    // fill the rob with no completions
    while (ref_rob.size() < `RN_ROB_DEPTH) begin
      @(negedge clock);
      drive_random(1'b1, 1'b0);
    end
    dispatch_valid = 1'b1;
    hold_count     = accept_count;
    repeat (4) begin
      @(negedge clock);
      drive_random(1'b1, 1'b0);
      // full rob stalls the held request
      check(32'(dispatch_ready), 32'(0), "dispatch_ready while full");
      check(32'(rob_count), 32'(`RN_ROB_DEPTH), "rob_count while full");
      check(32'(free_count), 32'(`RN_NUM_PHYS - `RN_NUM_ARCH - `RN_ROB_DEPTH),
            "free_count while full");
    end

    // completions again until the held dispatch gets in
    while (accept_count == hold_count) begin
      @(negedge clock);
      drive_random(1'b1, 1'b1);
    end
    drain_all();

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
+incdir+test
common/reg_pkg.sv
common/rob_pkg.sv
rename/map_table.sv
rename/free_list.sv
rename/arch_map.sv
rob/reorder_buffer.sv
rtl/cdb_select.sv
rtl/rename_core.sv
test/tb_rename_core.sv

// File: Makefile
# Verilator build for the rename core testbench

TOOL     = verilator
FLAGS    = --timing
TOP      = tb_rename_core
FILELIST = src.f
BUILD    = obj_dir

.PHONY: all lint sim clean

all: sim

# static checks of the whole source list
lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run, a $$fatal in the run gives a failing exit status
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
